//--- dataframe_config.svh
`ifndef DATAFRAME_CONFIG_SVH
`define DATAFRAME_CONFIG_SVH

// descriptor word and stream beat
`define DATAFRAME_WIDTH 16
`define TDATA_WIDTH 32

// fields of descriptor word 0
`define HEADER_ID_WIDTH 4
`define CH_ID_WIDTH 4
`define FRAME_LEN_WIDTH 8

// lines per frame, header needs at least 2
`define HEADER_LINE 3
`define FOOTER_LINE 1

// fifo depths
`define HF_FIFO_DEPTH 4
`define ADC_FIFO_DEPTH 64

// all-ones pad above a header or footer word
`define LINE_PAD_WIDTH (`TDATA_WIDTH - `DATAFRAME_WIDTH)

// bits in one full descriptor
`define HF_DESC_WIDTH ((`HEADER_LINE + `FOOTER_LINE) * `DATAFRAME_WIDTH)

`endif

//--- dataframe_pkg.sv
`default_nettype none

`include "dataframe_config.svh"

package dataframe_pkg;

    // one record per frame, word 0 in the top bits
    typedef struct packed {
        logic [`HEADER_ID_WIDTH-1:0] header_id;
        logic [`CH_ID_WIDTH-1:0]     ch_id;
        logic [`FRAME_LEN_WIDTH-1:0] frame_len;  // payload samples, never 0
        logic [`HEADER_LINE-2:0][`DATAFRAME_WIDTH-1:0] hdr_free;
        logic [`FOOTER_LINE-1:0][`DATAFRAME_WIDTH-1:0] footer;
    } hf_desc_t;

    typedef logic [`TDATA_WIDTH-1:0] adc_word_t;

    // source of the beat being built
    typedef enum logic [1:0] {
        LINE_HEAD,
        LINE_DATA,
        LINE_FOOT
    } line_sel_t;

endpackage

`default_nettype wire

//--- frame_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module frame_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  depth     = 4
) (
    input  wire logic     ACLK,
    input  wire logic     arst_n,
    input  wire logic     wr_en,
    input  wire payload_t wr_data,
    input  wire logic     rd_en,
    output payload_t      rd_data,
    output logic          empty,
    output logic          full
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t mem [depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_wr;
    logic             do_rd;

    assign empty = (count == '0);
    assign full  = (count == cnt_w'(depth));
    assign do_wr = wr_en && !full;   // writes into a full fifo are lost
    assign do_rd = rd_en && !empty;

    always_ff @(posedge ACLK or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge ACLK) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // registered read, held until the next pop
    always_ff @(posedge ACLK or negedge arst_n) begin
        if (!arst_n) begin
            rd_data <= '0;
        end else if (do_rd) begin
            rd_data <= mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

//--- frame_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

`include "dataframe_config.svh"

module frame_sequencer (
    input  wire logic                        ACLK,
    input  wire logic                        arst_n,
    input  wire logic                        hf_empty,
    input  wire logic                        adc_empty,
    input  wire logic [`FRAME_LEN_WIDTH-1:0] frame_len,
    input  wire logic                        stall,
    output logic                             hf_rd_en,
    output logic                             adc_rd_en,
    output dataframe_pkg::line_sel_t         line_sel,
    output logic [1:0]                       line_idx,
    output logic                             beat_load,
    output logic                             beat_last,
    output logic                             flush,
    output logic                             error
);

    localparam int cnt_w = `FRAME_LEN_WIDTH + 1;

    logic             active;
    logic [cnt_w-1:0] cnt;       // beat index inside the frame
    logic [cnt_w-1:0] cnt_inc;
    logic [cnt_w-1:0] data_end;  // index of first footer beat
    logic [cnt_w-1:0] last_idx;
    logic             next_is_data;
    logic             need_pop;
    logic             err_now;

    assign cnt_inc  = cnt + 1'b1;
    assign data_end = cnt_w'(`HEADER_LINE) + cnt_w'(frame_len);
    assign last_idx = data_end + cnt_w'(`FOOTER_LINE - 1);

    // samples are popped one beat ahead
    assign next_is_data = active && (cnt_inc >= cnt_w'(`HEADER_LINE)) && (cnt_inc < data_end);
    assign need_pop     = next_is_data && !stall;
    assign err_now      = need_pop && adc_empty;  // sample due but none there
    assign adc_rd_en    = need_pop && !adc_empty;

    assign beat_load = active && !err_now;
    assign beat_last = active && (cnt == last_idx);
    assign flush     = err_now;

    // next descriptor is popped during the final footer beat
    assign hf_rd_en = !stall && !error && !hf_empty && (!active || beat_last);

    always_comb begin
        if (cnt < cnt_w'(`HEADER_LINE)) begin
            line_sel = dataframe_pkg::LINE_HEAD;
            line_idx = cnt[1:0];
        end else if (cnt < data_end) begin
            line_sel = dataframe_pkg::LINE_DATA;
            line_idx = 2'd0;
        end else begin
            line_sel = dataframe_pkg::LINE_FOOT;
            line_idx = 2'(cnt - data_end);
        end
    end

    always_ff @(posedge ACLK or negedge arst_n) begin
        if (!arst_n) begin
            active <= 1'b0;
            cnt    <= '0;
            error  <= 1'b0;
        end else if (!error && !stall) begin
            if (err_now) begin
                active <= 1'b0;  // abort, idle until reset
                cnt    <= '0;
                error  <= 1'b1;
            end else if (active) begin
                if (beat_last) begin
                    active <= hf_rd_en;  // back to back if one is waiting
                    cnt    <= '0;
                end else begin
                    cnt <= cnt_inc;
                end
            end else if (hf_rd_en) begin
                active <= 1'b1;
                cnt    <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- line_builder.sv
`timescale 1ns/100ps
`default_nettype none

`include "dataframe_config.svh"

module line_builder (
    input  wire logic                        ACLK,
    input  wire logic                        arst_n,
    input  wire dataframe_pkg::hf_desc_t     desc,
    input  wire dataframe_pkg::adc_word_t    sample,
    input  wire dataframe_pkg::line_sel_t    line_sel,
    input  wire logic [1:0]                  line_idx,
    output logic [`TDATA_WIDTH-1:0]          line_data,
    output logic [`FRAME_LEN_WIDTH-1:0]      frame_len
);

    dataframe_pkg::hf_desc_t   desc_q;
    logic                      first_line;
    logic [`HF_DESC_WIDTH-1:0] src_bits;

    // first header beat still reads the fifo output directly
    assign first_line = (line_sel == dataframe_pkg::LINE_HEAD) && (line_idx == 2'd0);
    assign src_bits   = first_line ? desc : desc_q;
    assign frame_len  = desc_q.frame_len;

    always_ff @(posedge ACLK or negedge arst_n) begin
        if (!arst_n) begin
            desc_q <= '0;
        end else if (first_line) begin
            desc_q <= desc;  // fifo is free to pop the next one
        end
    end

    always_comb begin
        case (line_sel)
            dataframe_pkg::LINE_HEAD: line_data = {{`LINE_PAD_WIDTH{1'b1}},
                src_bits[(`HEADER_LINE + `FOOTER_LINE - 1 - int'(line_idx)) * `DATAFRAME_WIDTH
                         +: `DATAFRAME_WIDTH]};
            dataframe_pkg::LINE_FOOT: line_data = {{`LINE_PAD_WIDTH{1'b1}},
                src_bits[(`FOOTER_LINE - 1 - int'(line_idx)) * `DATAFRAME_WIDTH
                         +: `DATAFRAME_WIDTH]};
            default: line_data = sample;  // payload passes through
        endcase
    end

endmodule

`default_nettype wire

//--- stream_out_reg.sv
`timescale 1ns/100ps
`default_nettype none

`include "dataframe_config.svh"

module stream_out_reg (
    input  wire logic                    ACLK,
    input  wire logic                    arst_n,
    input  wire logic                    beat_load,
    input  wire logic [`TDATA_WIDTH-1:0] beat_data,
    input  wire logic                    beat_last,
    input  wire logic                    flush,
    input  wire logic                    m_axis_tready,
    output logic                         m_axis_tvalid,
    output logic [`TDATA_WIDTH-1:0]      m_axis_tdata,
    output logic                         m_axis_tlast,
    output logic                         stall
);

    // beat waiting on the sink
    assign stall = m_axis_tvalid && !m_axis_tready;

    always_ff @(posedge ACLK or negedge arst_n) begin
        if (!arst_n) begin
            m_axis_tvalid <= 1'b0;
            m_axis_tlast  <= 1'b0;
        end else if (flush) begin
            m_axis_tvalid <= 1'b0;
            m_axis_tlast  <= 1'b0;
        end else if (!stall) begin
            m_axis_tvalid <= beat_load;  // drops when nothing is loaded
            m_axis_tlast  <= beat_load && beat_last;
        end
    end

    always_ff @(posedge ACLK) begin
        if (beat_load && !stall) begin
            m_axis_tdata <= beat_data;
        end
    end

endmodule

`default_nettype wire

//--- dataframe_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "dataframe_config.svh"

module dataframe_top (
    input  wire logic                     ACLK,
    input  wire logic                     arst_n,
    input  wire logic                     hf_wr_en,
    input  wire dataframe_pkg::hf_desc_t  hf_wr_data,
    output logic                          hf_full,
    input  wire logic                     adc_wr_en,
    input  wire dataframe_pkg::adc_word_t adc_wr_data,
    output logic                          adc_full,
    input  wire logic                     m_axis_tready,
    output logic                          m_axis_tvalid,
    output logic [`TDATA_WIDTH-1:0]       m_axis_tdata,
    output logic                          m_axis_tlast,
    output logic                          dataframe_error
);

    dataframe_pkg::hf_desc_t   hf_rd_data;
    dataframe_pkg::adc_word_t  adc_rd_data;
    dataframe_pkg::line_sel_t  line_sel;
    logic                      hf_rd_en;
    logic                      hf_empty;
    logic                      adc_rd_en;
    logic                      adc_empty;
    logic [1:0]                line_idx;
    logic [`FRAME_LEN_WIDTH-1:0] frame_len;
    logic [`TDATA_WIDTH-1:0]   line_data;
    logic                      beat_load;
    logic                      beat_last;
    logic                      flush;
    logic                      stall;

    frame_fifo #(.payload_t(dataframe_pkg::hf_desc_t), .depth(`HF_FIFO_DEPTH)) u_hf_fifo (
        .ACLK(ACLK), .arst_n(arst_n),
        .wr_en(hf_wr_en), .wr_data(hf_wr_data),
        .rd_en(hf_rd_en), .rd_data(hf_rd_data),
        .empty(hf_empty), .full(hf_full)
    );

    frame_fifo #(.payload_t(dataframe_pkg::adc_word_t), .depth(`ADC_FIFO_DEPTH)) u_adc_fifo (
        .ACLK(ACLK), .arst_n(arst_n),
        .wr_en(adc_wr_en), .wr_data(adc_wr_data),
        .rd_en(adc_rd_en), .rd_data(adc_rd_data),
        .empty(adc_empty), .full(adc_full)
    );

    frame_sequencer u_seq (
        .ACLK(ACLK), .arst_n(arst_n),
        .hf_empty(hf_empty), .adc_empty(adc_empty), .frame_len(frame_len), .stall(stall),
        .hf_rd_en(hf_rd_en), .adc_rd_en(adc_rd_en),
        .line_sel(line_sel), .line_idx(line_idx),
        .beat_load(beat_load), .beat_last(beat_last), .flush(flush), .error(dataframe_error)
    );

    line_builder u_lines (
        .ACLK(ACLK), .arst_n(arst_n),
        .desc(hf_rd_data), .sample(adc_rd_data),
        .line_sel(line_sel), .line_idx(line_idx),
        .line_data(line_data), .frame_len(frame_len)
    );

    stream_out_reg u_out (
        .ACLK(ACLK), .arst_n(arst_n),
        .beat_load(beat_load), .beat_data(line_data), .beat_last(beat_last), .flush(flush),
        .m_axis_tready(m_axis_tready), .m_axis_tvalid(m_axis_tvalid),
        .m_axis_tdata(m_axis_tdata), .m_axis_tlast(m_axis_tlast), .stall(stall)
    );

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int period_ns    = 4,
    parameter int reset_cycles = 4
) (
    output logic ACLK,
    output logic arst_n
);

    initial begin
        ACLK = 1'b0;
        forever #(period_ns / 2) ACLK = ~ACLK;
    end

    // released just after an edge
    initial begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge ACLK);
        #1 arst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- tb_dataframe.sv
`timescale 1ns/100ps
`default_nettype none

`include "dataframe_config.svh"

module tb_dataframe #(
    parameter int seed_value = 76
);

    localparam int quiet_cycles = 40;

    logic                     ACLK;
    logic                     arst_n;
    logic                     hf_wr_en;
    dataframe_pkg::hf_desc_t  hf_wr_data;
    logic                     hf_full;
    logic                     adc_wr_en;
    dataframe_pkg::adc_word_t adc_wr_data;
    logic                     adc_full;
    logic                     m_axis_tready;
    logic                     m_axis_tvalid;
    logic [`TDATA_WIDTH-1:0]  m_axis_tdata;
    logic                     m_axis_tlast;
    logic                     dataframe_error;

    // one entry per input line
    dataframe_pkg::hf_desc_t  desc_q[$];
    int                       count_q[$];
    int                       beats_q[$];
    bit                       stall_q[$];
    bit                       err_q[$];
    // every expected beat, in stream order
    dataframe_pkg::adc_word_t exp_data_q[$];
    logic                     exp_last_q[$];

    int  seed;
    int  rnd;
    int  total_beats;
    int  cycle_cnt   = 0;
    int  cycle_limit = 100000;
    int  cur_frame;
    int  cur_beat;
    int  frames_done;
    int  samp_wr;               // samples taken by the fifo
    int  samp_acc;              // payload beats taken by the sink
    int  desc_wr;
    bit  stall_on;
    bit  error_seen;
    bit  pend;                  // beat held by back-pressure
    dataframe_pkg::adc_word_t prev_data;
    logic                     prev_last;

    tb_clock_gen #(.period_ns(4), .reset_cycles(4)) u_clk (.ACLK(ACLK), .arst_n(arst_n));

    dataframe_top DUT (
        .ACLK(ACLK), .arst_n(arst_n),
        .hf_wr_en(hf_wr_en), .hf_wr_data(hf_wr_data), .hf_full(hf_full),
        .adc_wr_en(adc_wr_en), .adc_wr_data(adc_wr_data), .adc_full(adc_full),
        .m_axis_tready(m_axis_tready), .m_axis_tvalid(m_axis_tvalid),
        .m_axis_tdata(m_axis_tdata), .m_axis_tlast(m_axis_tlast),
        .dataframe_error(dataframe_error)
    );

    function automatic dataframe_pkg::adc_word_t sample_value(input int k);
        return dataframe_pkg::adc_word_t'(32'hAD00_0000 + k);
    endfunction

    // word 0 is the top word of the descriptor
    function automatic dataframe_pkg::adc_word_t desc_line(input dataframe_pkg::hf_desc_t d,
                                                           input int w);
        logic [`HF_DESC_WIDTH-1:0] bits;
        bits = d;
        return {{(`TDATA_WIDTH - `DATAFRAME_WIDTH){1'b1}},
                bits[`HF_DESC_WIDTH - 1 - w * `DATAFRAME_WIDTH -: `DATAFRAME_WIDTH]};
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_beat(input dataframe_pkg::adc_word_t exp_data, input logic exp_last);
        if (m_axis_tdata !== exp_data)
            abort_run($sformatf("ERR m_axis_tdata got %h expected %h (frame %0d beat %0d)",
                                m_axis_tdata, exp_data, cur_frame, cur_beat));
        if (m_axis_tlast !== exp_last)
            abort_run($sformatf("ERR m_axis_tlast got %h expected %h (frame %0d beat %0d)",
                                m_axis_tlast, exp_last, cur_frame, cur_beat));
    endtask

    task automatic check_strobes(input logic exp_valid, input logic exp_last);
        if (m_axis_tvalid !== exp_valid || m_axis_tlast !== exp_last)
            abort_run($sformatf("ERR m_axis_tvalid/m_axis_tlast got %h/%h expected %h/%h",
                                m_axis_tvalid, m_axis_tlast, exp_valid, exp_last));
    endtask

    task automatic check_error(input logic exp_flag);
        if (dataframe_error !== exp_flag)
            abort_run($sformatf("ERR dataframe_error got %h expected %h (frame %0d)",
                                dataframe_error, exp_flag, cur_frame));
    endtask

    // up to two popped items may sit between the fifo and the sink
    task automatic check_full(input string name, input logic got, input int most,
                              input int depth);
        if (most < depth && got !== 1'b0)
            abort_run($sformatf("ERR %s got %h expected %h", name, got, 1'b0));
        if (most - 2 >= depth && got !== 1'b1)
            abort_run($sformatf("ERR %s got %h expected %h", name, got, 1'b1));
    endtask

    task automatic check_fifo_flags;
        check_full("adc_full", adc_full, samp_wr - samp_acc, `ADC_FIFO_DEPTH);
        check_full("hf_full", hf_full, desc_wr - frames_done, `HF_FIFO_DEPTH);
    endtask

    task automatic load_input;
        int                        fd;
        int                        r;
        int                        i;
        int                        k;
        int                        len;
        int                        cnt;
        int                        st;
        int                        er;
        string                     text;
        logic [`HF_DESC_WIDTH-1:0] raw;
        dataframe_pkg::hf_desc_t   dd;
        fd = $fopen("dataframe_input.txt", "r");
        if (fd == 0) abort_run("cannot open dataframe_input.txt");
        total_beats = 0;
        k = 0;
        while (!$feof(fd)) begin
            text = "";
            r = $fgets(text, fd);
            r = $sscanf(text, "%h %d %d %d", raw, cnt, st, er);
            if (r == 4) begin
                dd = raw;
                len = int'(dd.frame_len);
                if (err_q.size() > 0 && err_q[err_q.size() - 1])
                    abort_run("input file has lines after the error case");
                if (len == 0 || cnt > `ADC_FIFO_DEPTH)
                    abort_run("input file has a zero frame length or too many samples");
                if ((er == 0 && cnt != len) || (er != 0 && cnt >= len))
                    abort_run("input file sample count does not fit the frame length");
                desc_q.push_back(dd);
                count_q.push_back(cnt);
                beats_q.push_back(`HEADER_LINE + len + `FOOTER_LINE);
                stall_q.push_back(st != 0);
                err_q.push_back(er != 0);
                for (i = 0; i < `HEADER_LINE; i++) begin
                    exp_data_q.push_back(desc_line(dd, i));
                    exp_last_q.push_back(1'b0);
                end
                for (i = 0; i < len; i++) begin
                    exp_data_q.push_back(sample_value(k));
                    exp_last_q.push_back(1'b0);
                    k++;
                end
                for (i = 0; i < `FOOTER_LINE; i++) begin
                    exp_data_q.push_back(desc_line(dd, `HEADER_LINE + i));
                    exp_last_q.push_back(i == `FOOTER_LINE - 1);
                end
                total_beats += `HEADER_LINE + len + `FOOTER_LINE;
            end
        end
        $fclose(fd);
        if (desc_q.size() == 0) abort_run("input file holds no frames");
    endtask

    // entered at 1 ns after an edge, returns there too
    task automatic push_sample(input dataframe_pkg::adc_word_t d);
        while (adc_full) begin
            @(posedge ACLK);
            #1;
        end
        adc_wr_en   = 1'b1;
        adc_wr_data = d;
        @(posedge ACLK);
        #1;
        adc_wr_en = 1'b0;
        samp_wr++;
    endtask

    task automatic push_desc(input dataframe_pkg::hf_desc_t d);
        while (hf_full) begin
            @(posedge ACLK);
            #1;
        end
        hf_wr_en   = 1'b1;
        hf_wr_data = d;
        @(posedge ACLK);
        #1;
        hf_wr_en = 1'b0;
        desc_wr++;
    endtask

    // samples of a frame go in before its descriptor
    task automatic write_stimulus;
        int f;
        int i;
        int k;
        k = 0;
        for (f = 0; f < desc_q.size(); f++) begin
            for (i = 0; i < count_q[f]; i++) begin
                push_sample(sample_value(k));
                k++;
            end
            push_desc(desc_q[f]);
        end
    endtask

    task automatic check_hold;
        if (pend) begin
            check_strobes(1'b1, prev_last);
            check_beat(prev_data, prev_last);
        end
        pend      = m_axis_tvalid && !m_axis_tready;
        prev_data = m_axis_tdata;
        prev_last = m_axis_tlast;
    endtask

    // sampled mid-cycle, a beat moves on the next rising edge
    task automatic check_stream;
        int f;
        int base;
        int max_beats;
        int data_end;
        base = 0;
        for (f = 0; f < desc_q.size(); f++) begin
            // the beat loaded with the failed pop is flushed
            max_beats = err_q[f] ? `HEADER_LINE + count_q[f] - 1 : beats_q[f];
            data_end  = beats_q[f] - `FOOTER_LINE;
            cur_frame = f;
            cur_beat  = 0;
            stall_on  = stall_q[f];
            while (cur_beat < beats_q[f] && !error_seen) begin
                @(negedge ACLK);
                check_hold();
                check_fifo_flags();
                if (err_q[f] && dataframe_error) begin
                    error_seen = 1'b1;
                    check_strobes(1'b0, 1'b0);  // flushed with the abort
                    if (cur_beat != max_beats)
                        abort_run($sformatf("frame %0d aborted after %0d beats instead of %0d",
                                            f, cur_beat, max_beats));
                end else begin
                    check_error(1'b0);
                    if (m_axis_tvalid) begin
                        if (cur_beat >= max_beats)
                            abort_run($sformatf("frame %0d sent beat %0d without its sample",
                                                f, cur_beat));
                        check_beat(exp_data_q[base + cur_beat], exp_last_q[base + cur_beat]);
                        if (m_axis_tready) begin
                            if (cur_beat >= `HEADER_LINE && cur_beat < data_end) samp_acc++;
                            cur_beat++;
                        end
                    end
                end
            end
            base += beats_q[f];
            frames_done++;
        end
    endtask

    always @(posedge ACLK) begin
        #1;
        if (stall_on) begin
            rnd = $random(seed);
            m_axis_tready = (rnd[1:0] != 2'b00);  // ready about 3 cycles in 4
        end else begin
            m_axis_tready = 1'b1;
        end
    end

    always @(posedge ACLK) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout after %0d cycles, the stream never finished", cycle_limit);
            $display("STATUS: FAIL");
            $fatal(1, "timeout");
        end
    end

    initial begin
        hf_wr_en      = 1'b0;
        hf_wr_data    = '0;
        adc_wr_en     = 1'b0;
        adc_wr_data   = '0;
        m_axis_tready = 1'b1;
        seed          = seed_value;
        stall_on      = 1'b0;
        error_seen    = 1'b0;
        pend          = 1'b0;
        frames_done   = 0;
        samp_wr       = 0;
        samp_acc      = 0;
        desc_wr       = 0;
        cur_frame     = 0;
        cur_beat      = 0;
        load_input();
        cycle_limit = 20 * total_beats + 200;
        wait (arst_n === 1'b1);
        @(negedge ACLK);
        check_strobes(1'b0, 1'b0);
        check_error(1'b0);
        check_fifo_flags();
        @(posedge ACLK);
        #1;
        fork
            write_stimulus();
            check_stream();
        join
        repeat (quiet_cycles) begin
            @(negedge ACLK);
            check_hold();
            check_fifo_flags();
            check_strobes(1'b0, 1'b0);
            check_error(error_seen);
        end
        if (frames_done == desc_q.size() && error_seen == err_q[err_q.size() - 1]) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("checked %0d of %0d frames, error flag seen %0b",
                     frames_done, desc_q.size(), error_seen);
            $display("STATUS: FAIL");
            $fatal(1, "frame count or error flag wrong at end of run");
        end
    end

endmodule

`default_nettype wire

//--- dataframe_input.txt
// descriptor (hex, word 0 first)  samples written  stall enable  error case
// word 0 = header_id ch_id frame_len; the error case writes fewer samples than frame_len
1A04A0B1A0B2F0D1 4 0 0
2B01A1B1A1B2F0D2 1 0 0
3C02A2B1A2B2F0D3 2 0 0
4D10A3B1A3B2F0D4 16 1 0
5E08A4B1A4B2F0D5 8 1 0
6F20A5B1A5B2F0D6 32 1 0
7001A6B1A6B2F0D7 1 1 0
8105A7B1A7B2F0D8 5 1 0
9203A8B1A8B2F0D9 3 0 0
A140A9B1A9B2F0DA 64 1 0
B20CAAB1AAB2F0DB 12 0 0
C301ABB1ABB2F0DC 1 1 0
D302ACB1ACB2F0DD 2 0 0
E308ADB1ADB2F0DE 5 1 1

//--- filelist.f
+incdir+.
dataframe_pkg.sv
frame_fifo.sv
frame_sequencer.sv
line_builder.sv
stream_out_reg.sv
dataframe_top.sv
tb_clock_gen.sv
tb_dataframe.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_dataframe
SEED      ?= 76
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build filelist.f with Verilator and run $(TOP) (SEED=$(SEED))"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "variables: VERILATOR TOP SEED OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f filelist.f --top-module $(TOP) -Gseed_value=$(SEED) \
		-Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
